/* hdl/soc_cfg.svh */
`ifndef SOC_CFG_SVH
`define SOC_CFG_SVH

// host and apb address width
`define SOC_ADDR_W 12

// register data width
`define SOC_DATA_W 32

// number of led driver slots
`define SOC_N_SLOTS 2

// led pins per slot
`define SOC_LED_BITS 2

// slot field sits in addr[11:8]
`define SOC_SEL_LSB 8
`define SOC_SEL_W 4

// slot field values of the mapped responders
`define SOC_INTC_SEL 0
// led slot k answers at base + k
`define SOC_SLOT_BASE_SEL 1

`endif

/* hdl/soc_pkg.sv */
`default_nettype none

`include "soc_cfg.svh"

package soc_pkg;

	// apb bundle from master to decoder and responders
	// psel is produced per slot by the decoder
	typedef struct packed {
		logic                   write;
		logic [`SOC_ADDR_W-1:0] addr;
		logic [`SOC_DATA_W-1:0] wdata;
		logic                   enable;
	} apb_req_t;

	// one responder answer, zero when not selected
	typedef struct packed {
		logic [`SOC_DATA_W-1:0] rdata;
		logic                   ack;
		logic                   err;
	} apb_rsp_t;

	// host side request, valid with req_valid
	typedef struct packed {
		logic                   write;
		logic [`SOC_ADDR_W-1:0] addr;
		logic [`SOC_DATA_W-1:0] wdata;
	} host_req_t;

	// host side response, valid with resp_valid
	typedef struct packed {
		logic [`SOC_DATA_W-1:0] rdata;
		logic                   err;
	} host_rsp_t;

	// apb sequencer states
	typedef enum logic [1:0] {
		IDLE   = 2'd0,
		SETUP  = 2'd1,
		ACCESS = 2'd2
	} apb_state_e;

	// interrupt controller offsets within its slot
	typedef enum logic [2:0] {
		REG_STATUS = 3'd0,
		REG_MASK   = 3'd4
	} intc_reg_e;

endpackage

`default_nettype wire

/* hdl/apb_master.sv */
`timescale 1ns/10ps
`default_nettype none

module apb_master (
	input  wire logic                apb_clk,
	input  wire logic                arst_n,

	input  wire logic                req_valid,
	input  wire soc_pkg::host_req_t  req,
	output logic                     resp_valid,
	output soc_pkg::host_rsp_t       resp,
	output logic                     busy,

	output soc_pkg::apb_req_t        apb_req,
	output logic                     psel_any,
	input  wire soc_pkg::apb_rsp_t   apb_rsp
);

	soc_pkg::apb_state_e state;
	soc_pkg::host_req_t  req_q;
	logic                access_done;

	// ack only counts in the access phase
	assign access_done = (state == soc_pkg::ACCESS) && apb_rsp.ack;

	// psel covers setup and access
	assign psel_any = (state != soc_pkg::IDLE);
	// busy drops together with the response pulse
	assign busy = psel_any;

	// request fields held for the whole transfer
	assign apb_req.write  = req_q.write;
	assign apb_req.addr   = req_q.addr;
	assign apb_req.wdata  = req_q.wdata;
	assign apb_req.enable = (state == soc_pkg::ACCESS);

	always_ff @(posedge apb_clk or negedge arst_n) begin
		if (!arst_n) begin
			state <= soc_pkg::IDLE;
		end else begin
			case (state)
				soc_pkg::IDLE: begin
					if (req_valid) begin
						state <= soc_pkg::SETUP;
					end
				end
				// one setup cycle, then enable
				soc_pkg::SETUP: begin
					state <= soc_pkg::ACCESS;
				end
				// wait states until some responder acks
				soc_pkg::ACCESS: begin
					if (apb_rsp.ack) begin
						state <= soc_pkg::IDLE;
					end
				end
				default: begin
					state <= soc_pkg::IDLE;
				end
			endcase
		end
	end

	// capture host request on accept
	always_ff @(posedge apb_clk) begin
		if ((state == soc_pkg::IDLE) && req_valid) begin
			req_q <= req;
		end
	end

	// response pulse one cycle after ack
	always_ff @(posedge apb_clk or negedge arst_n) begin
		if (!arst_n) begin
			resp_valid <= 1'b0;
		end else begin
			resp_valid <= access_done;
		end
	end

	always_ff @(posedge apb_clk) begin
		if (access_done) begin
			resp.rdata <= apb_rsp.rdata;
			resp.err   <= apb_rsp.err;
		end
	end

	// host must wait for the previous response
	a_no_req_while_busy: assert property (@(posedge apb_clk) disable iff (!arst_n)
		req_valid |-> !busy);

	// enable never rises without a setup cycle before it
	a_enable_after_setup: assert property (@(posedge apb_clk) disable iff (!arst_n)
		$rose(apb_req.enable) |-> $past(psel_any));

endmodule

`default_nettype wire

/* hdl/apb_decoder.sv */
`timescale 1ns/10ps
`default_nettype none

`include "soc_cfg.svh"

module apb_decoder (
	input  wire soc_pkg::apb_req_t        apb_req,
	input  wire logic                     psel_any,

	output logic [`SOC_N_SLOTS-1:0]       sel,
	output logic                          sel_intc,
	output logic                          unmapped
);

	logic [`SOC_SEL_W-1:0] field;

	// slot field of the current address
	assign field = apb_req.addr[`SOC_SEL_LSB +: `SOC_SEL_W];

	// led slot k sits right after the controller
	always_comb begin
		sel = '0;
		for (int k = 0; k < `SOC_N_SLOTS; k++) begin
			sel[k] = psel_any && (int'(field) == `SOC_SLOT_BASE_SEL + k);
		end
	end

	// controller slot
	assign sel_intc = psel_any && (int'(field) == `SOC_INTC_SEL);

	// nothing matched, merger answers with an error
	assign unmapped = psel_any && !sel_intc && !(|sel);

	// map overlap would select two responders at once
	always_comb begin
		a_sel_onehot: assert ($onehot0({sel, sel_intc, unmapped}))
			else $error("apb_decoder: more than one select active");
	end

endmodule

`default_nettype wire

/* hdl/apb_resp_merge.sv */
`timescale 1ns/10ps
`default_nettype none

`include "soc_cfg.svh"

module apb_resp_merge (
	input  wire logic                                  apb_clk,
	input  wire logic                                  arst_n,

	input  wire soc_pkg::apb_req_t                     apb_req,
	input  wire logic                                  unmapped,
	input  wire soc_pkg::apb_rsp_t [`SOC_N_SLOTS-1:0]  slot_rsp,
	input  wire soc_pkg::apb_rsp_t                     intc_rsp,

	output soc_pkg::apb_rsp_t                          apb_rsp
);

	soc_pkg::apb_rsp_t       rsp_or;
	logic                    err_q;
	logic                    err_ack;
	logic [`SOC_N_SLOTS:0]   acks;

	// idle responders drive zero, so a plain or drains them
	always_comb begin
		rsp_or  = intc_rsp;
		acks[0] = intc_rsp.ack;
		for (int k = 0; k < `SOC_N_SLOTS; k++) begin
			rsp_or.rdata = rsp_or.rdata | slot_rsp[k].rdata;
			rsp_or.ack   = rsp_or.ack | slot_rsp[k].ack;
			rsp_or.err   = rsp_or.err | slot_rsp[k].err;
			acks[k+1]    = slot_rsp[k].ack;
		end
	end

	// unmapped access gets one wait state, then error
	always_ff @(posedge apb_clk or negedge arst_n) begin
		if (!arst_n) begin
			err_q <= 1'b0;
		end else begin
			err_q <= unmapped && apb_req.enable && !err_q;
		end
	end

	assign err_ack = err_q && unmapped && apb_req.enable;

	// rdata stays zero on error since nobody is selected
	assign apb_rsp.rdata = rsp_or.rdata;
	assign apb_rsp.ack   = rsp_or.ack | err_ack;
	assign apb_rsp.err   = rsp_or.err | err_ack;

	// one responder per transfer
	a_single_ack: assert property (@(posedge apb_clk) disable iff (!arst_n)
		$onehot0({acks, err_ack}));

endmodule

`default_nettype wire

/* hdl/led_slot.sv */
`timescale 1ns/10ps
`default_nettype none

`include "soc_cfg.svh"

module led_slot (
	input  wire logic                    apb_clk,
	input  wire logic                    arst_n,

	input  wire soc_pkg::apb_req_t       apb_req,
	input  wire logic                    sel,

	output soc_pkg::apb_rsp_t            apb_rsp,
	output logic [`SOC_LED_BITS-1:0]     led,
	output logic                         wr_event
);

	logic [`SOC_DATA_W-1:0] data_q;
	logic                   wait_q;
	logic                   acc;
	logic                   ack;

	// selected and in access phase
	assign acc = sel && apb_req.enable;

	// ack in the second access cycle
	assign ack = acc && wait_q;

	// wait flop, cleared again with the ack
	always_ff @(posedge apb_clk or negedge arst_n) begin
		if (!arst_n) begin
			wait_q <= 1'b0;
		end else begin
			wait_q <= acc && !wait_q;
		end
	end

	// data register, written on the acked write only
	always_ff @(posedge apb_clk or negedge arst_n) begin
		if (!arst_n) begin
			data_q <= '0;
		end else if (ack && apb_req.write) begin
			data_q <= apb_req.wdata;
		end
	end

	// zero when idle so the merger can or
	assign apb_rsp.rdata = ack ? data_q : '0;
	assign apb_rsp.ack   = ack;
	assign apb_rsp.err   = 1'b0;

	// low bits go to the pins
	assign led = data_q[`SOC_LED_BITS-1:0];

	// event toward the interrupt controller
	assign wr_event = ack && apb_req.write;

endmodule

`default_nettype wire

/* hdl/int_controller.sv */
`timescale 1ns/10ps
`default_nettype none

`include "soc_cfg.svh"

module int_controller (
	input  wire logic                      apb_clk,
	input  wire logic                      arst_n,

	input  wire soc_pkg::apb_req_t         apb_req,
	input  wire logic                      sel,
	input  wire logic [`SOC_N_SLOTS-1:0]   src_event,

	output soc_pkg::apb_rsp_t              apb_rsp,
	output logic                           int_o
);

	logic [`SOC_N_SLOTS-1:0] status_q;
	logic [`SOC_N_SLOTS-1:0] mask_q;
	logic [`SOC_N_SLOTS-1:0] clr_bits;
	logic                    int_q;
	logic                    acc;
	logic                    wr_status;
	logic                    wr_mask;
	soc_pkg::intc_reg_e      reg_sel;
	logic [`SOC_DATA_W-1:0]  rd_word;

	// register offset inside the slot
	assign reg_sel = soc_pkg::intc_reg_e'(apb_req.addr[2:0]);

	// no wait state, ack in first access cycle
	assign acc = sel && apb_req.enable;

	assign wr_status = acc && apb_req.write && (reg_sel == soc_pkg::REG_STATUS);
	assign wr_mask   = acc && apb_req.write && (reg_sel == soc_pkg::REG_MASK);

	// write one to clear
	assign clr_bits = wr_status ? apb_req.wdata[`SOC_N_SLOTS-1:0] : '0;

	// status bits, a new event beats the clear
	always_ff @(posedge apb_clk or negedge arst_n) begin
		if (!arst_n) begin
			status_q <= '0;
		end else begin
			status_q <= (status_q & ~clr_bits) | src_event;
		end
	end

	// mask register
	always_ff @(posedge apb_clk or negedge arst_n) begin
		if (!arst_n) begin
			mask_q <= '0;
		end else if (wr_mask) begin
			mask_q <= apb_req.wdata[`SOC_N_SLOTS-1:0];
		end
	end

	// registered interrupt line
	always_ff @(posedge apb_clk or negedge arst_n) begin
		if (!arst_n) begin
			int_q <= 1'b0;
		end else begin
			int_q <= |(status_q & mask_q);
		end
	end

	assign int_o = int_q;

	// read mux, unknown offsets read zero
	always_comb begin
		rd_word = '0;
		case (reg_sel)
			soc_pkg::REG_STATUS: rd_word[`SOC_N_SLOTS-1:0] = status_q;
			soc_pkg::REG_MASK:   rd_word[`SOC_N_SLOTS-1:0] = mask_q;
			default:             rd_word = '0;
		endcase
	end

	// quiet bus when not selected
	assign apb_rsp.rdata = acc ? rd_word : '0;
	assign apb_rsp.ack   = acc;
	assign apb_rsp.err   = 1'b0;

endmodule

`default_nettype wire

/* hdl/soc_apb_top.sv */
`timescale 1ns/10ps
`default_nettype none

`include "soc_cfg.svh"

module soc_apb_top (
	input  wire logic                                 apb_clk,
	input  wire logic                                 arst_n,

	input  wire logic                                 req_valid,
	input  wire soc_pkg::host_req_t                   req,
	output logic                                      resp_valid,
	output soc_pkg::host_rsp_t                        resp,
	output logic                                      busy,

	output logic [`SOC_N_SLOTS*`SOC_LED_BITS-1:0]     led,
	output logic                                      int_o
);

	// apb request and selects
	soc_pkg::apb_req_t                     apb_req;
	logic                                  psel_any;
	logic [`SOC_N_SLOTS-1:0]               sel;
	logic                                  sel_intc;
	logic                                  unmapped;

	// responder answers
	soc_pkg::apb_rsp_t [`SOC_N_SLOTS-1:0]  slot_rsp;
	soc_pkg::apb_rsp_t                     intc_rsp;
	soc_pkg::apb_rsp_t                     apb_rsp;

	// slot write events into the controller
	logic [`SOC_N_SLOTS-1:0]               wr_event;

	apb_master master0 (
		.apb_clk    (apb_clk    ),
		.arst_n     (arst_n     ),
		.req_valid  (req_valid  ),
		.req        (req        ),
		.resp_valid (resp_valid ),
		.resp       (resp       ),
		.busy       (busy       ),
		.apb_req    (apb_req    ),
		.psel_any   (psel_any   ),
		.apb_rsp    (apb_rsp    )
	);

	apb_decoder decoder0 (
		.apb_req    (apb_req    ),
		.psel_any   (psel_any   ),
		.sel        (sel        ),
		.sel_intc   (sel_intc   ),
		.unmapped   (unmapped   )
	);

	// slot 0 drives the lowest led pins
	for (genvar k = 0; k < `SOC_N_SLOTS; k++) begin : g_slot
		led_slot slot (
			.apb_clk  (apb_clk                                 ),
			.arst_n   (arst_n                                  ),
			.apb_req  (apb_req                                 ),
			.sel      (sel[k]                                  ),
			.apb_rsp  (slot_rsp[k]                             ),
			.led      (led[k*`SOC_LED_BITS +: `SOC_LED_BITS]   ),
			.wr_event (wr_event[k]                             )
		);
	end

	apb_resp_merge merge0 (
		.apb_clk    (apb_clk    ),
		.arst_n     (arst_n     ),
		.apb_req    (apb_req    ),
		.unmapped   (unmapped   ),
		.slot_rsp   (slot_rsp   ),
		.intc_rsp   (intc_rsp   ),
		.apb_rsp    (apb_rsp    )
	);

	int_controller intc0 (
		.apb_clk    (apb_clk    ),
		.arst_n     (arst_n     ),
		.apb_req    (apb_req    ),
		.sel        (sel_intc   ),
		.src_event  (wr_event   ),
		.apb_rsp    (intc_rsp   ),
		.int_o      (int_o      )
	);

endmodule

`default_nettype wire

/* tests/tb_soc_apb.sv */
`timescale 1ns/10ps
`default_nettype none

`include "soc_cfg.svh"

module tb_soc_apb;

	localparam int RESP_TIMEOUT = 20;

	// one table row per host access
	typedef struct packed {
		logic                   write;
		logic [`SOC_ADDR_W-1:0] addr;
		logic [`SOC_DATA_W-1:0] wdata;
		logic                   rnd;
		logic                   exp_err;
		logic                   chk;
	} row_t;

	logic                                   apb_clk;
	logic                                   arst_n;
	logic                                   req_valid;
	soc_pkg::host_req_t                     req;
	logic                                   resp_valid;
	soc_pkg::host_rsp_t                     resp;
	logic                                   busy;
	logic [`SOC_N_SLOTS*`SOC_LED_BITS-1:0]  led;
	logic                                   int_o;

	row_t rows[$];

	// reference model state
	logic [`SOC_DATA_W-1:0]  m_slot [`SOC_N_SLOTS];
	logic [`SOC_N_SLOTS-1:0] m_status;
	logic [`SOC_N_SLOTS-1:0] m_mask;

	soc_apb_top dut0 (
		.apb_clk    (apb_clk   ),
		.arst_n     (arst_n    ),
		.req_valid  (req_valid ),
		.req        (req       ),
		.resp_valid (resp_valid),
		.resp       (resp      ),
		.busy       (busy      ),
		.led        (led       ),
		.int_o      (int_o     )
	);

	initial begin
		apb_clk = 1'b0;
		forever #5 apb_clk = ~apb_clk;
	end

	task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
		assert (got === exp) else begin
			$display("[FAIL] time %0t %s got %h expected %h", $time, name, got, exp);
			$display("Test FAILED");
			$fatal(1);
		end
	endtask

	task automatic fail_timeout(input string what);
		$display("timeout at %0t while waiting for %s", $time, what);
		$display("Test FAILED");
		$fatal(1);
	endtask

	task automatic add_row(input logic wr, input logic [11:0] addr, input logic [31:0] wdata,
			input logic rnd, input logic exp_err, input logic chk);
		row_t r;
		r.write   = wr;
		r.addr    = addr;
		r.wdata   = wdata;
		r.rnd     = rnd;
		r.exp_err = exp_err;
		r.chk     = chk;
		rows.push_back(r);
	endtask

	// address map and register rules, returns expected read word
	task automatic model_access(input row_t r, output logic [31:0] exp_rdata);
		int field;
		int k;
		field = int'(r.addr[`SOC_SEL_LSB +: `SOC_SEL_W]);
		k = field - `SOC_SLOT_BASE_SEL;
		exp_rdata = '0;
		if (field == `SOC_INTC_SEL) begin
			// status at offset 0, mask at offset 4
			if (r.addr[2:0] == 3'd0) begin
				exp_rdata[`SOC_N_SLOTS-1:0] = m_status;
				if (r.write) m_status = m_status & ~r.wdata[`SOC_N_SLOTS-1:0];
			end else if (r.addr[2:0] == 3'd4) begin
				exp_rdata[`SOC_N_SLOTS-1:0] = m_mask;
				if (r.write) m_mask = r.wdata[`SOC_N_SLOTS-1:0];
			end
		end else if (k >= 0 && k < `SOC_N_SLOTS) begin
			exp_rdata = m_slot[k];
			if (r.write) begin
				m_slot[k] = r.wdata;
				m_status[k] = 1'b1;
			end
		end
	endtask

	function automatic logic [31:0] model_led();
		logic [31:0] v;
		v = '0;
		for (int k = 0; k < `SOC_N_SLOTS; k++) begin
			v[k*`SOC_LED_BITS +: `SOC_LED_BITS] = m_slot[k][`SOC_LED_BITS-1:0];
		end
		return v;
	endfunction

	// one host access, wait for the response pulse
	task automatic run_row(input row_t r);
		logic [31:0] exp_rdata;
		int n;
		model_access(r, exp_rdata);
		@(posedge apb_clk);
		req_valid <= 1'b1;
		req.write <= r.write;
		req.addr  <= r.addr;
		req.wdata <= r.wdata;
		@(posedge apb_clk);
		req_valid <= 1'b0;
		n = 0;
		@(negedge apb_clk);
		while (!resp_valid) begin
			// busy holds through setup and access
			check_val("busy", 32'(busy), 32'd1);
			n++;
			if (n > RESP_TIMEOUT) fail_timeout("resp_valid");
			@(negedge apb_clk);
		end
		check_val("busy", 32'(busy), 32'd0);
		check_val("resp.err", 32'(resp.err), 32'(r.exp_err));
		// write responses carry no defined data unless unmapped
		if (!r.write || r.exp_err) begin
			check_val("resp.rdata", resp.rdata, exp_rdata);
		end
		@(negedge apb_clk);
		// single pulse per access
		check_val("resp_valid", 32'(resp_valid), 32'd0);
		check_val("busy", 32'(busy), 32'd0);
		if (r.chk) begin
			check_val("led", 32'(led), model_led());
			check_val("int_o", 32'(int_o), 32'(|(m_status & m_mask)));
		end
	endtask

	initial begin
		void'($urandom(27));
		arst_n    = 1'b0;
		req_valid = 1'b0;
		req       = '0;
		m_status  = '0;
		m_mask    = '0;
		for (int k = 0; k < `SOC_N_SLOTS; k++) m_slot[k] = '0;

		// reads after reset
		add_row(1'b0, 12'h100, 32'h0, 1'b0, 1'b0, 1'b1);
		add_row(1'b0, 12'h200, 32'h0, 1'b0, 1'b0, 1'b1);
		add_row(1'b0, 12'h000, 32'h0, 1'b0, 1'b0, 1'b1);
		add_row(1'b0, 12'h004, 32'h0, 1'b0, 1'b0, 1'b1);
		// slot write and readback
		add_row(1'b1, 12'h100, 32'h0, 1'b1, 1'b0, 1'b1);
		add_row(1'b1, 12'h200, 32'h0, 1'b1, 1'b0, 1'b1);
		add_row(1'b0, 12'h100, 32'h0, 1'b0, 1'b0, 1'b1);
		add_row(1'b0, 12'h200, 32'h0, 1'b0, 1'b0, 1'b1);
		// unmapped slot fields
		add_row(1'b0, 12'h300, 32'h0, 1'b0, 1'b1, 1'b1);
		add_row(1'b1, 12'hF00, 32'h0, 1'b1, 1'b1, 1'b1);
		add_row(1'b0, 12'hF04, 32'h0, 1'b0, 1'b1, 1'b1);
		add_row(1'b1, 12'h3FC, 32'h0, 1'b1, 1'b1, 1'b1);
		// status set by slot writes, mask opens int_o
		add_row(1'b0, 12'h000, 32'h0, 1'b0, 1'b0, 1'b1);
		add_row(1'b1, 12'h004, 32'h1, 1'b0, 1'b0, 1'b1);
		add_row(1'b0, 12'h004, 32'h0, 1'b0, 1'b0, 1'b1);
		add_row(1'b1, 12'h004, 32'h2, 1'b0, 1'b0, 1'b1);
		// write one to clear
		add_row(1'b1, 12'h000, 32'h1, 1'b0, 1'b0, 1'b1);
		add_row(1'b0, 12'h000, 32'h0, 1'b0, 1'b0, 1'b1);
		add_row(1'b1, 12'h000, 32'h2, 1'b0, 1'b0, 1'b1);
		add_row(1'b0, 12'h000, 32'h0, 1'b0, 1'b0, 1'b1);
		add_row(1'b1, 12'h100, 32'h0, 1'b1, 1'b0, 1'b1);
		add_row(1'b1, 12'h004, 32'h3, 1'b0, 1'b0, 1'b1);
		add_row(1'b1, 12'h000, 32'h3, 1'b0, 1'b0, 1'b1);
		add_row(1'b0, 12'h004, 32'h0, 1'b0, 1'b0, 1'b1);
		add_row(1'b0, 12'h200, 32'h0, 1'b0, 1'b0, 1'b1);

		// random write data
		foreach (rows[i]) begin
			if (rows[i].rnd) rows[i].wdata = $urandom;
		end

		repeat (2) @(posedge apb_clk);
		arst_n <= 1'b1;
		@(negedge apb_clk);
		check_val("led", 32'(led), 32'd0);
		check_val("int_o", 32'(int_o), 32'd0);
		check_val("busy", 32'(busy), 32'd0);
		check_val("resp_valid", 32'(resp_valid), 32'd0);

		foreach (rows[i]) begin
			run_row(rows[i]);
		end

		$display("Test OK");
		$finish;
	end

endmodule

`default_nettype wire

/* src.f */
+incdir+hdl
hdl/soc_pkg.sv
hdl/apb_master.sv
hdl/apb_decoder.sv
hdl/apb_resp_merge.sv
hdl/led_slot.sv
hdl/int_controller.sv
hdl/soc_apb_top.sv
tests/tb_soc_apb.sv

/* run.sh */
#!/bin/sh
# build and run the testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f src.f --top-module tb_soc_apb -o sim_tb \
	&& ./obj_dir/sim_tb | grep "Test OK" \
	&& echo "simulation passed" \
	|| { echo "simulation failed"; exit 1; }
